// File: include/ethRt_macros.svh
// Shared constants for the real-time Ethernet switch
// The switch logic handles exactly two PHY ports, so do not change ETH_NUM_PORTS
`ifndef ETHRT_MACROS_SVH
`define ETHRT_MACROS_SVH

// ----------------------------------------
// Port count
// ----------------------------------------
`define ETH_NUM_PORTS 2        // Single-bit curPort assumes two ports

// ----------------------------------------
// Frame layout
// ----------------------------------------
`define ETH_RECV_FLUSH_BIT 31  // Flush flag in the receive info word
`define ETH_FRAME_BEGIN 0      // Send byte offset of the first frame byte

`endif

// File: design/ethRtPkg.sv
// Types shared by the switch blocks and the testbench
// Info word layouts follow the PHY-side FIFO format and are fixed at 32 bits
package ethRtPkg;

    // ----------------------------------------
    // Info words
    // ----------------------------------------

    // Receive info word as written by the PHY receive side
    typedef struct packed {
        logic        flush;      // Frame must be drained, not delivered
        logic [6:0]  spare0;
        logic [7:0]  firstByte;  // First data byte seen by the PHY side
        logic [3:0]  spare1;
        logic [11:0] byteCount;  // Frame length in bytes
    } rxInfo_t;

    // Send info word closing each frame in the send info FIFO
    typedef struct packed {
        logic        flush;      // Set on send FIFO overflow
        logic [6:0]  zero;
        logic [7:0]  firstByte;  // First byte handed to the send FIFO
        logic [15:0] byteCount;  // Response byte count from the host
    } txInfo_t;

    // ----------------------------------------
    // Per-port groups
    // ----------------------------------------

    // Receive FIFO outputs of one port, all FWFT
    typedef struct packed {
        logic        dataEmpty;
        logic [15:0] dout;
        logic        infoEmpty;
        rxInfo_t     info;
    } phyRxPort_t;

    // Send-side status of one port
    typedef struct packed {
        logic initOK;         // PHY link is up and configured
        logic resetActive;    // PHY side in reset
        logic sendFull;       // Send data FIFO full
        logic infoFull;       // Send info FIFO full
        logic internalError;
    } phyTxPort_t;

    // Core FSM states
    typedef enum logic [1:0] {
        stIdle,
        stRecvWait,
        stRecv,
        stSend
    } coreState_t;

endpackage

// File: design/rxPortSelect.sv
// Receive side port selection for the two-port switch
// Port flip only happens while the core reports idle; data pops follow curPort
`include "ethRt_macros.svh"

module rxPortSelect (
    input  logic                                           clk,
    input  logic                                           reset,
    input  ethRtPkg::phyRxPort_t [`ETH_NUM_PORTS-1:0]      rxPorts,
    input  ethRtPkg::phyTxPort_t [`ETH_NUM_PORTS-1:0]      txStatus,
    input  logic                                           bwActive,
    input  logic                                           idle,
    input  logic                                           infoTake,
    input  logic                                           dataPop,
    input  logic                                           firstByteBad,
    output logic                                           curPort,
    output ethRtPkg::rxInfo_t                              curInfo,
    output logic                                           infoValid,
    output logic [15:0]                                    recvWord,
    output logic [`ETH_NUM_PORTS-1:0]                      recvRdEn,
    output logic [`ETH_NUM_PORTS-1:0]                      recvInfoRdEn,
    output logic [`ETH_NUM_PORTS-1:0]                      recvFifoError,
    output logic                                           resetActiveOut,
    output logic                                           ethInternalError
);

    logic [`ETH_NUM_PORTS-1:0] pending;    // Port has a frame we may take now
    logic [`ETH_NUM_PORTS-1:0] portReset;

    always_comb begin
        for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
            pending[p]   = txStatus[p].initOK & ~bwActive & ~rxPorts[p].infoEmpty;
            portReset[p] = txStatus[p].resetActive;
        end
    end

    assign infoValid        = pending[curPort];
    assign curInfo          = rxPorts[curPort].info;   // FWFT word is valid while not empty
    assign recvWord         = rxPorts[curPort].dout;
    assign resetActiveOut   = |portReset;               // Host sees either PHY reset
    assign ethInternalError = txStatus[curPort].internalError;

    // Flip toward the other port when only that port has work
    always_ff @(posedge clk) begin
        if (reset) begin
            curPort <= 1'b0;
        end else if (idle && !pending[curPort] && pending[~curPort]) begin
            curPort <= ~curPort;
        end
    end

    // Pop strobes go to the current port only
    always_comb begin
        recvRdEn              = '0;
        recvInfoRdEn          = '0;
        recvRdEn[curPort]     = dataPop;
        recvInfoRdEn[curPort] = infoTake;
    end

    // Sticky first-byte errors that a PHY reset clears per port
    always_ff @(posedge clk) begin
        if (reset) begin
            recvFifoError <= '0;
        end else begin
            recvFifoError <= recvFifoError & ~portReset;
            if (firstByteBad)
                recvFifoError[curPort] <= 1'b1;
        end
    end

    // Core word count must never outrun the current port's data FIFO
    assert property (@(posedge clk) disable iff (reset)
        (|recvRdEn) |-> !rxPorts[curPort].dataEmpty);

endmodule

// File: design/ethSwitchCore.sv
// Switch core FSM that picks a receive or forward send and sequences receive words
// Only one direction is active at a time; this suits the request/response protocol
// Info fields are latched at the decision since the info FIFO pops right after
`include "ethRt_macros.svh"

module ethSwitchCore (
    input  logic              clk,
    input  logic              reset,
    input  ethRtPkg::rxInfo_t curInfo,
    input  logic              infoValid,
    input  logic [15:0]       recvWord,
    input  logic              sendReq,           // Forward request from the forwarding side
    input  logic              sendFifoFullCur,   // Current port cannot take a send
    input  logic              responseRequired,
    input  logic              recvBusy,
    input  logic              sendDone,
    output logic              idle,
    output logic              infoTake,
    output logic              dataPop,
    output logic              firstByteBad,
    output logic              recvRequest,
    output logic              recvReady,
    output logic              isForward,
    output logic              sendStart
);

    ethRtPkg::coreState_t state;

    logic [11:0] wordCount;      // Last word index of the frame
    logic [11:0] recvCnt;        // Words handled so far
    logic [7:0]  expFirstByte;   // First byte from the info word
    logic        frameValid;     // 0 -> drain without host
    logic        dataValid;      // Word consumed by host
    logic        recvTransition; // Word done so count or finish
    logic        recvWait;       // Spacer before next recvReady
    logic        forwardGo;
    logic        frameFlush;

    assign frameFlush = curInfo[`ETH_RECV_FLUSH_BIT];
    assign forwardGo  = sendReq & ~sendFifoFullCur;

    // Idle with no forward send starting, so the port may be switched
    assign idle = (state == ethRtPkg::stIdle) & ~forwardGo;

    always_ff @(posedge clk) begin
        infoTake     <= 1'b0;     // Pulses default low
        dataPop      <= 1'b0;
        firstByteBad <= 1'b0;
        sendStart    <= 1'b0;
        if (reset) begin
            state          <= ethRtPkg::stIdle;
            recvRequest    <= 1'b0;
            recvReady      <= 1'b0;
            isForward      <= 1'b0;
            frameValid     <= 1'b0;
            dataValid      <= 1'b0;
            recvTransition <= 1'b0;
            recvWait       <= 1'b0;
            recvCnt        <= 12'd0;
        end else begin
            case (state)
                // ----------------------------------------
                ethRtPkg::stIdle: begin
                    isForward <= 1'b0;
                    recvCnt   <= 12'd0;
                    if (forwardGo) begin
                        isForward <= 1'b1;        // Forward wins over receive
                        sendStart <= 1'b1;
                        state     <= ethRtPkg::stSend;
                    end else if (infoValid) begin
                        // Words = ((bytes+3)/2 rounded down to even) + 1
                        wordCount      <= ((curInfo.byteCount + 12'd3) >> 1) & 12'hffe;
                        expFirstByte   <= curInfo.firstByte;
                        infoTake       <= 1'b1;
                        frameValid     <= ~frameFlush;
                        recvRequest    <= ~frameFlush;  // No host request on flush
                        recvReady      <= 1'b0;
                        dataValid      <= 1'b0;
                        recvWait       <= 1'b0;
                        recvTransition <= frameFlush;   // Flushed frames pop one word per cycle
                        state          <= frameFlush ? ethRtPkg::stRecv
                                                     : ethRtPkg::stRecvWait;
                    end
                end
                // ----------------------------------------
                ethRtPkg::stRecvWait: begin
                    if (recvBusy) begin               // Host accepted the request
                        recvRequest <= 1'b0;
                        recvReady   <= 1'b1;
                        state       <= ethRtPkg::stRecv;
                    end
                end
                // ----------------------------------------
                ethRtPkg::stRecv: begin
                    if (frameValid) begin
                        // 4-phase ring of ready, valid, transition and wait
                        recvReady      <= recvWait;
                        dataValid      <= recvReady;
                        recvTransition <= dataValid;
                        recvWait       <= recvTransition;
                    end
                    dataPop <= dataValid | ~frameValid;
                    if (dataValid && recvCnt == 12'd0)
                        firstByteBad <= (recvWord[15:8] != expFirstByte);
                    if (recvTransition) begin
                        if (recvCnt == wordCount) begin
                            sendStart <= frameValid & responseRequired;
                            state     <= (frameValid & responseRequired) ? ethRtPkg::stSend
                                                                         : ethRtPkg::stIdle;
                        end else begin
                            recvCnt <= recvCnt + 12'd1;
                        end
                    end
                end
                // ----------------------------------------
                ethRtPkg::stSend: begin
                    if (sendDone)
                        state <= ethRtPkg::stIdle;    // Writer closed the frame
                end
            endcase
        end
    end

    // Host strobe and FIFO pop are always apart in the word ring
    assert property (@(posedge clk) disable iff (reset) !(recvReady && dataPop));

    // Writer only reports done for a send the core started
    assert property (@(posedge clk) disable iff (reset)
        sendDone |-> (state == ethRtPkg::stSend));

endmodule

// File: design/txFrameWriter.sv
// Send side that pulls host words and byte-swaps them into the current port's send FIFO
// curPort must stay fixed for the whole send; the core guarantees this
// Overflow turns the rest of the frame into a flush, flagged in the info word
`include "ethRt_macros.svh"

module txFrameWriter (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      sendStart,
    input  logic                                      curPort,
    input  ethRtPkg::phyTxPort_t [`ETH_NUM_PORTS-1:0] txStatus,
    input  logic                                      sendBusy,
    input  logic [15:0]                               sendWord,
    input  logic [15:0]                               responseByteCount,
    output logic                                      sendRequest,
    output logic                                      sendReady,
    output logic [`ETH_NUM_PORTS-1:0]                 sendWrEn,
    output logic [15:0]                               sendFifoDin,
    output logic [`ETH_NUM_PORTS-1:0]                 sendInfoWrEn,
    output ethRtPkg::txInfo_t                         sendInfoDin,
    output logic [`ETH_NUM_PORTS-1:0]                 sendFifoOverflow,
    output logic                                      sendDone
);

    logic [2:0]  sendCtrl;     // One-hot ring of ready, capture and count
    logic        sendActive;
    logic        sendFlush;    // Drop remaining words after overflow
    logic [11:0] sendCnt;      // Bytes sent
    logic [7:0]  firstByte;
    logic [`ETH_NUM_PORTS-1:0] portReset;

    always_comb begin
        for (int p = 0; p < `ETH_NUM_PORTS; p++)
            portReset[p] = txStatus[p].resetActive;
    end

    assign sendReady             = sendCtrl[0];
    assign sendInfoDin.flush     = sendFlush;
    assign sendInfoDin.zero      = 7'd0;
    assign sendInfoDin.firstByte = firstByte;
    assign sendInfoDin.byteCount = responseByteCount;

    always_ff @(posedge clk) begin
        sendWrEn     <= '0;
        sendInfoWrEn <= '0;
        sendDone     <= 1'b0;
        if (reset) begin
            sendRequest      <= 1'b0;
            sendCtrl         <= 3'b100;   // Parked with sendReady low
            sendActive       <= 1'b0;
            sendFlush        <= 1'b0;
            sendFifoOverflow <= '0;
        end else begin
            sendFifoOverflow <= sendFifoOverflow & ~portReset;
            if (sendStart) begin
                sendRequest <= 1'b1;
                sendCnt     <= 12'd0;
            end else if (sendRequest) begin
                if (sendBusy) begin
                    sendRequest <= 1'b0;
                    sendFlush   <= 1'b0;
                    sendCtrl    <= 3'b001;
                    sendActive  <= 1'b1;
                end
            end else if (sendActive) begin
                if (sendBusy) begin
                    sendCtrl <= {sendCtrl[1:0], sendCtrl[2]};
                    if (sendCtrl[1]) begin
                        sendFifoDin       <= {sendWord[7:0], sendWord[15:8]};
                        sendWrEn[curPort] <= ~(txStatus[curPort].sendFull | sendFlush);
                        if (txStatus[curPort].sendFull) begin
                            sendFlush                 <= 1'b1;
                            sendFifoOverflow[curPort] <= 1'b1;
                        end
                        if (sendCnt == 12'(`ETH_FRAME_BEGIN))
                            firstByte <= sendWord[7:0];   // Goes out first on the wire
                    end else if (sendCtrl[2]) begin
                        sendCnt <= sendCnt + 12'd2;
                    end
                end else begin
                    // Host dropped busy so the frame closes
                    sendCtrl              <= 3'b100;
                    sendActive            <= 1'b0;
                    sendInfoWrEn[curPort] <= 1'b1;
                    sendDone              <= 1'b1;
                end
            end
        end
    end

    // A write never lands on a full send FIFO
    assert property (@(posedge clk) disable iff (reset)
        sendWrEn[curPort] |-> !txStatus[curPort].sendFull);

endmodule

// File: design/ethSwitchRt.sv
// Real-time Ethernet switch between two PHY ports and the host protocol engine
// Receive and send never overlap; forward sends go out on the current port
`include "ethRt_macros.svh"

module ethSwitchRt (
    input  logic                                      clk,
    input  logic                                      reset,
    // PHY side
    input  ethRtPkg::phyRxPort_t [`ETH_NUM_PORTS-1:0] rxPorts,
    input  ethRtPkg::phyTxPort_t [`ETH_NUM_PORTS-1:0] txStatus,
    output logic [`ETH_NUM_PORTS-1:0]                 recvRdEn,
    output logic [`ETH_NUM_PORTS-1:0]                 recvInfoRdEn,
    output logic [`ETH_NUM_PORTS-1:0]                 sendWrEn,
    output logic [15:0]                               sendFifoDin,
    output logic [`ETH_NUM_PORTS-1:0]                 sendInfoWrEn,
    output ethRtPkg::txInfo_t                         sendInfoDin,
    output logic [`ETH_NUM_PORTS-1:0]                 recvFifoError,
    output logic [`ETH_NUM_PORTS-1:0]                 sendFifoOverflow,
    // Host side
    input  logic                                      sendReq,
    output logic                                      resetActiveOut,
    output logic                                      isForward,
    input  logic                                      responseRequired,
    input  logic [15:0]                               responseByteCount,
    output logic                                      recvRequest,
    input  logic                                      recvBusy,
    output logic                                      recvReady,
    output logic [15:0]                               recvWord,
    output logic                                      sendRequest,
    input  logic                                      sendBusy,
    output logic                                      sendReady,
    input  logic [15:0]                               sendWord,
    input  logic                                      bwActive,
    output logic                                      curPort,
    output logic                                      ethInternalError
);

    ethRtPkg::rxInfo_t curInfo;
    logic infoValid, idle, infoTake, dataPop, firstByteBad;
    logic sendStart, sendDone, sendFifoFullCur;

    // A port that is not up counts as full for forwarding
    assign sendFifoFullCur = ~txStatus[curPort].initOK | txStatus[curPort].sendFull
                           | txStatus[curPort].infoFull;

    rxPortSelect rxSel (
        .clk, .reset, .rxPorts, .txStatus, .bwActive, .idle, .infoTake, .dataPop,
        .firstByteBad, .curPort, .curInfo, .infoValid, .recvWord, .recvRdEn,
        .recvInfoRdEn, .recvFifoError, .resetActiveOut, .ethInternalError
    );

    ethSwitchCore core (
        .clk, .reset, .curInfo, .infoValid, .recvWord, .sendReq, .sendFifoFullCur,
        .responseRequired, .recvBusy, .sendDone, .idle, .infoTake, .dataPop,
        .firstByteBad, .recvRequest, .recvReady, .isForward, .sendStart
    );

    txFrameWriter txWr (
        .clk, .reset, .sendStart, .curPort, .txStatus, .sendBusy, .sendWord,
        .responseByteCount, .sendRequest, .sendReady, .sendWrEn, .sendFifoDin,
        .sendInfoWrEn, .sendInfoDin, .sendFifoOverflow, .sendDone
    );

endmodule

// File: tb/ethSwitchRt_tb.sv
// Testbench for ethSwitchRt with FWFT PHY FIFO models and a host engine model
// Both ports stay up; one frame is in flight at a time
`include "ethRt_macros.svh"

module ethSwitchRt_tb;

    localparam int Timeout = 2000;   // Cycles allowed per wait
    localparam int NoFull  = 255;    // Send FIFO never forced full

    logic clk, reset, sendReq, responseRequired, recvBusy, sendBusy, bwActive;
    logic [15:0] responseByteCount, sendWord, recvWord, sendFifoDin, tmp;
    logic resetActiveOut, isForward, recvRequest, recvReady, sendRequest, sendReady;
    logic curPort, ethInternalError;
    logic [`ETH_NUM_PORTS-1:0] recvRdEn, recvInfoRdEn, sendWrEn, sendInfoWrEn;
    logic [`ETH_NUM_PORTS-1:0] recvFifoError, sendFifoOverflow;
    ethRtPkg::phyRxPort_t [`ETH_NUM_PORTS-1:0] rxPorts;
    ethRtPkg::phyTxPort_t [`ETH_NUM_PORTS-1:0] txStatus;
    ethRtPkg::txInfo_t sendInfoDin;
    ethRtPkg::rxInfo_t infoDrop;

    logic [15:0] rxD0[$], rxD1[$], txD0[$], txD1[$], expQ[$], gotWords[$], sentQ[$];
    ethRtPkg::rxInfo_t rxI0[$], rxI1[$];
    ethRtPkg::txInfo_t txI0[$], txI1[$];
    int unsigned seed = 97500;
    int errors = 0, checks = 0, reqSeen, readySeen, sendWords, fullAt, sentCount;
    // port, bytes, flush, firstByte, corrupt, respReq, respWords, fullAt
    int tab [0:5][0:7];

    ethSwitchRt dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lcgNext();
        seed = seed * 1103515245 + 12345;
        return seed[30:15];
    endfunction

    // ----------------------------------------
    // FWFT PHY FIFO models
    // ----------------------------------------
    always @(posedge clk) begin
        if (recvRdEn[0] && rxD0.size() > 0) tmp = rxD0.pop_front();
        if (recvRdEn[1] && rxD1.size() > 0) tmp = rxD1.pop_front();
        if (recvInfoRdEn[0] && rxI0.size() > 0) infoDrop = rxI0.pop_front();
        if (recvInfoRdEn[1] && rxI1.size() > 0) infoDrop = rxI1.pop_front();
        rxPorts[0].dataEmpty <= (rxD0.size() == 0);
        rxPorts[0].dout      <= (rxD0.size() > 0) ? rxD0[0] : 16'h0;
        rxPorts[0].infoEmpty <= (rxI0.size() == 0);
        rxPorts[0].info      <= (rxI0.size() > 0) ? rxI0[0] : '0;
        rxPorts[1].dataEmpty <= (rxD1.size() == 0);
        rxPorts[1].dout      <= (rxD1.size() > 0) ? rxD1[0] : 16'h0;
        rxPorts[1].infoEmpty <= (rxI1.size() == 0);
        rxPorts[1].info      <= (rxI1.size() > 0) ? rxI1[0] : '0;
        if (sendWrEn[0]) txD0.push_back(sendFifoDin);     // Send FIFO capture
        if (sendWrEn[1]) txD1.push_back(sendFifoDin);
        if (sendInfoWrEn[0]) txI0.push_back(sendInfoDin);
        if (sendInfoWrEn[1]) txI1.push_back(sendInfoDin);
    end

    // Host engine model with random busy latency
    always @(posedge clk) begin : hostModel
        logic [15:0] w;
        if (recvRequest) reqSeen++;
        if (recvReady) begin
            readySeen++;
            gotWords.push_back(recvWord);                   // Word stable at ready
        end
        if (recvRequest && !recvBusy) begin
            if (lcgNext() % 3 == 0) recvBusy <= 1'b1;
        end else if (!recvRequest) begin
            recvBusy <= 1'b0;
        end
        if (sendRequest && !sendBusy) begin
            if (lcgNext() % 3 == 0) begin
                sendBusy <= 1'b1;
                sentCount = 0;
            end
        end else if (sendBusy && sendReady) begin
            if (sentCount == sendWords) begin
                sendBusy <= 1'b0;                           // Ends the send
            end else begin
                w = lcgNext();
                sendWord <= w;
                sentQ.push_back(w);
                if (sentCount == fullAt) txStatus[curPort].sendFull <= 1'b1;
                sentCount++;
            end
        end
    end

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abortRun(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("test failed");
        $finish;
    endtask

    function automatic int rxLeft(input int p);
        return (p == 0) ? rxD0.size() + rxI0.size() : rxD1.size() + rxI1.size();
    endfunction

    function automatic int txInfoCount(input int p);
        return (p == 0) ? txI0.size() : txI1.size();
    endfunction

    // Compare send FIFO contents with the swapped host words
    task automatic checkSend(input int p, input int nWrite, input logic ovf);
        ethRtPkg::txInfo_t info;
        checkVal("send words written", (p == 0) ? txD0.size() : txD1.size(), nWrite);
        for (int j = 0; j < nWrite; j++) begin
            tmp = (p == 0) ? txD0.pop_front() : txD1.pop_front();
            checkVal("sendFifoDin", tmp, {sentQ[j][7:0], sentQ[j][15:8]});
        end
        checkVal("send info writes", txInfoCount(p), 1);
        info = (p == 0) ? txI0.pop_front() : txI1.pop_front();
        checkVal("sendInfoDin.flush", info.flush, ovf);
        checkVal("sendInfoDin.firstByte", info.firstByte, sentQ[0][7:0]);
        checkVal("sendInfoDin.byteCount", info.byteCount, 2 * sendWords);
        txD0.delete();
        txD1.delete();
    endtask

    // PHY reset on one port clears its sticky flags
    task automatic pulsePortReset(input int p);
        @(posedge clk);
        txStatus[p].resetActive <= 1'b1;
        @(posedge clk);
        checkVal("resetActiveOut", resetActiveOut, 1);
        @(posedge clk);
        checkVal("recvFifoError", recvFifoError, 0);
        checkVal("sendFifoOverflow", sendFifoOverflow, 0);
        txStatus[p].resetActive <= 1'b0;
        txStatus[p].sendFull    <= 1'b0;
        @(posedge clk);
        checkVal("resetActiveOut", resetActiveOut, 0);
    endtask

    task automatic runCase(input int c);
        int p, n, t, nWrite;
        logic [15:0] w;
        ethRtPkg::rxInfo_t info;
        p = tab[c][0];
        n = ((tab[c][1] + 3) / 2 / 2) * 2 + 1;   // Words in the frame
        expQ.delete();
        gotWords.delete();
        sentQ.delete();
        reqSeen   = 0;
        readySeen = 0;
        sendWords = tab[c][6];
        fullAt    = tab[c][7];
        @(posedge clk);
        responseRequired  <= tab[c][5];
        responseByteCount <= 16'(2 * tab[c][6]);
        for (int j = 0; j < n; j++) begin
            w = lcgNext();
            if (j == 0) w[15:8] = tab[c][4] ? ~8'(tab[c][3]) : 8'(tab[c][3]);
            expQ.push_back(w);
            if (p == 0) rxD0.push_back(w);
            else rxD1.push_back(w);
        end
        info           = '0;
        info.flush     = tab[c][2];
        info.firstByte = tab[c][3];
        info.byteCount = tab[c][1];
        if (p == 0) rxI0.push_back(info);
        else rxI1.push_back(info);
        t = 0;
        while (rxLeft(p) != 0 || (tab[c][5] && !tab[c][2] && txInfoCount(p) == 0)) begin
            if (t++ > Timeout) abortRun("frame not consumed");
            @(posedge clk);
        end
        @(posedge clk);
        if (!tab[c][2]) begin
            checkVal("recv word count", gotWords.size(), n);
            for (int j = 0; j < n && j < gotWords.size(); j++)
                checkVal("recvWord", gotWords[j], expQ[j]);
        end else begin
            checkVal("recvRequest cycles", reqSeen, 0);   // Flush stays hidden
            checkVal("recvReady cycles", readySeen, 0);
        end
        checkVal("recvFifoError", recvFifoError, (tab[c][4] && !tab[c][2]) ? 1 << p : 0);
        nWrite = (fullAt < sendWords) ? fullAt : sendWords;
        if (tab[c][5] && !tab[c][2]) checkSend(p, nWrite, fullAt < sendWords);
        checkVal("sendFifoOverflow", sendFifoOverflow,
                 (tab[c][5] && fullAt < sendWords) ? 1 << p : 0);
        pulsePortReset(p);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : mainSeq
        int t;
        tab = '{'{0, 10, 0, 8'h5a, 0, 0, 0, NoFull},   // Valid frame
                '{0, 7,  1, 8'h11, 0, 0, 0, NoFull},   // Flushed frame
                '{0, 12, 0, 8'h33, 1, 0, 0, NoFull},   // Bad first byte
                '{0, 6,  0, 8'h44, 0, 1, 4, NoFull},   // Response send
                '{0, 8,  0, 8'h66, 0, 1, 5, 2},        // Overflow at word 2
                '{1, 9,  0, 8'h77, 0, 1, 3, NoFull}};  // Port 1 only
        reset = 1'b1;
        sendReq = 1'b0;
        responseRequired = 1'b0;
        responseByteCount = 16'h0;
        recvBusy = 1'b0;
        sendBusy = 1'b0;
        sendWord = 16'h0;
        bwActive = 1'b0;
        sendWords = 0;
        fullAt = NoFull;
        for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
            rxPorts[p] = '0;
            rxPorts[p].dataEmpty = 1'b1;
            rxPorts[p].infoEmpty = 1'b1;
            txStatus[p] = '0;
            txStatus[p].initOK = 1'b1;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int c = 0; c < 6; c++)
            runCase(c);
        // Forward send from idle on port 1
        sentQ.delete();
        sendWords = 2;
        fullAt = NoFull;
        @(posedge clk);
        responseRequired  <= 1'b0;
        responseByteCount <= 16'd4;
        sendReq           <= 1'b1;
        t = 0;
        while (!sendRequest) begin
            if (t++ > Timeout) abortRun("no forward send request");
            @(posedge clk);
        end
        checkVal("isForward", isForward, 1);
        checkVal("curPort", curPort, 1);
        sendReq <= 1'b0;
        t = 0;
        while (txInfoCount(1) == 0) begin
            if (t++ > Timeout) abortRun("forward info word missing");
            @(posedge clk);
        end
        checkSend(1, 2, 1'b0);
        // Internal error follows the current port only
        @(posedge clk);
        txStatus[0].internalError <= 1'b1;
        @(posedge clk);
        checkVal("ethInternalError", ethInternalError, 0);
        txStatus[1].internalError <= 1'b1;
        @(posedge clk);
        checkVal("ethInternalError", ethInternalError, 1);
        txStatus[0].internalError <= 1'b0;
        txStatus[1].internalError <= 1'b0;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
design/ethRtPkg.sv
design/rxPortSelect.sv
design/ethSwitchCore.sv
design/txFrameWriter.sv
design/ethSwitchRt.sv
tb/ethSwitchRt_tb.sv

// File: Bender.yml
package:
  name: ethSwitchRt

sources:
  - include_dirs:
      - include
    files:
      - design/ethRtPkg.sv
      - design/rxPortSelect.sv
      - design/ethSwitchCore.sv
      - design/txFrameWriter.sv
      - design/ethSwitchRt.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/ethSwitchRt_tb.sv
